//--- dv/icache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module icache_properties import icache_pkg::*; (
	input wire logic              clk,
	input wire logic              rst,
	input wire logic              req_valid,
	input wire logic              req_ready,
	input wire logic [ADDR_W-1:0] req_addr,
	input wire logic              resp_valid,
	input wire logic              resp_ready,
	input wire logic [WORD_W-1:0] resp_inst,
	input wire logic              flush,
	input wire logic              psel,
	input wire logic              penable,
	input wire logic              pready,
	input wire logic [ADDR_W-1:0] paddr
);

	int unsigned       fail_count = 0;
	logic [ADDR_W-1:0] pend [2];
	logic [1:0]        pend_n;
	logic              accept;
	logic              taken;
	logic [WORD_W-1:0] exp_inst;

	assign accept = req_valid && req_ready;
	assign taken = resp_valid && resp_ready;
	// memory rule is the word address xor a fixed pattern
	assign exp_inst = {pend[0][ADDR_W-1:2], 2'b00} ^ 32'h5A5A_0000;

	// accepted addresses not yet answered with at most one in lookup and one in response
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			pend_n <= '0;
		end else if (accept && !taken) begin
			pend[pend_n[0]] <= req_addr;
			pend_n <= pend_n + 1'b1;
		end else if (taken && !accept) begin
			pend[0] <= pend[1];
			pend_n <= pend_n - 1'b1;
		end else if (taken && accept) begin
			if (pend_n == 2'd1) begin
				pend[0] <= req_addr;
			end else begin
				pend[0] <= pend[1];
				pend[1] <= req_addr;
			end
		end
	end

	a_resp_word: assert property (@(posedge clk) disable iff (rst)
		taken |-> (pend_n != 0) && (resp_inst == exp_inst))
	else begin
		$error("ERR fetch_word: expected %h actual %h",
			$sampled(exp_inst), $sampled(resp_inst));
		fail_count++;
	end

	// response held while the consumer stalls
	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready && !flush |=> resp_valid && $stable(resp_inst))
	else begin
		$error("response changed or dropped while stalled");
		fail_count++;
	end

	a_stall_ready: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |-> !req_ready)
	else begin
		$error("request accepted while a response was stalled");
		fail_count++;
	end

	a_flush_kill: assert property (@(posedge clk) disable iff (rst)
		flush |=> !resp_valid)
	else begin
		$error("response still valid in the cycle after flush");
		fail_count++;
	end

	// apb setup is followed by access with a steady address
	a_apb_setup: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> psel && penable && $stable(paddr))
	else begin
		$error("apb setup phase not followed by access phase");
		fail_count++;
	end

	a_apb_wait: assert property (@(posedge clk) disable iff (rst)
		penable && !pready |=> penable && $stable(paddr))
	else begin
		$error("apb access left before pready");
		fail_count++;
	end

endmodule

bind icache_top icache_properties u_props (
	.clk(clk),
	.rst(rst),
	.req_valid(req_valid),
	.req_ready(req_ready),
	.req_addr(req_addr),
	.resp_valid(resp_valid),
	.resp_ready(resp_ready),
	.resp_inst(resp_inst),
	.flush(flush),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.paddr(paddr)
);

`default_nettype wire

//--- dv/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache import icache_pkg::*; ();

	localparam int NUM_REQS = 32;
	localparam int CLK_NS = 20;

	logic              clk;
	logic              rst;
	logic              req_valid;
	logic [ADDR_W-1:0] req_addr;
	logic              req_ready;
	logic              resp_valid;
	logic [WORD_W-1:0] resp_inst;
	logic              resp_ready;
	logic              flush;
	logic              psel;
	logic              penable;
	logic [ADDR_W-1:0] paddr;
	logic [31:0]       prdata;
	logic              pready;

	int                xfer_count;
	int                wait_left;
	logic [ADDR_W-1:0] apb_log [$];

	// reference model of the tags per set and way and the rotating victim pointer
	logic [TAG_W-1:0]  m_tag [64][4];
	bit                m_valid [64][4];
	int                m_ptr;

	icache_top #(
		.NUM_WAYS(4),
		.SETS(64)
	) UUT (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_inst(resp_inst),
		.resp_ready(resp_ready),
		.flush(flush),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.prdata(prdata),
		.pready(pready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input int exp, input int act);
		if (exp != act)
			abort_run($sformatf("ERR %s: expected 0x%0h actual 0x%0h", name, exp, act));
	endtask

	initial begin
		#((200 * NUM_REQS + 1000) * CLK_NS);
		abort_run("timeout: the run did not complete in the expected time");
	end

	always @(negedge clk) begin
		if (UUT.u_props.fail_count != 0)
			abort_run("a bound assertion reported a failure");
	end

	// apb memory with 0 to 3 wait states per transfer
	initial begin
		pready = 1'b0;
		prdata = '0;
		wait_left = 0;
		xfer_count = 0;
		forever begin
			@(posedge clk);
			#1;
			if (psel && !penable)
				wait_left = $urandom_range(3, 0);
			if (psel && penable) begin
				if (wait_left == 0) begin
					pready = 1'b1;
				end else begin
					pready = 1'b0;
					wait_left--;
				end
			end else begin
				pready = 1'b0;
			end
			prdata = paddr ^ 32'h5A5A_0000;
			// transfer completes at the coming edge
			if (psel && penable && pready) begin
				xfer_count++;
				apb_log.push_back(paddr);
			end
		end
	end

	// predicts the transfers for one accepted request and updates the mirror
	function automatic int model_access(input logic [ADDR_W-1:0] addr);
		int idx;
		logic [TAG_W-1:0] tag;
		int res;
		idx = addr[OFFSET_W +: INDEX_W];
		tag = addr[ADDR_W-1 -: TAG_W];
		res = WORDS_PER_LINE;
		for (int w = 0; w < 4; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == tag)
				res = 0;
		end
		if (res != 0) begin
			m_valid[idx][m_ptr] = 1'b1;
			m_tag[idx][m_ptr] = tag;
		end
		m_ptr = (m_ptr + 1) % 4;
		return res;
	endfunction

	task automatic send_req(input logic [ADDR_W-1:0] addr);
		req_valid = 1'b1;
		req_addr = addr;
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		req_valid = 1'b0;
	endtask

	task automatic take_resp(input int stall);
		@(negedge clk);
		while (!resp_valid)
			@(negedge clk);
		repeat (stall) @(posedge clk);
		if (stall > 0) begin
			#1;
			resp_ready = 1'b1;
		end
		@(posedge clk);
		#1;
	endtask

	task automatic fetch(input string name, input logic [ADDR_W-1:0] addr, input int stall);
		int exp;
		int start;
		exp = model_access(addr);
		start = xfer_count;
		if (stall > 0)
			resp_ready = 1'b0;
		send_req(addr);
		take_resp(stall);
		check_value(name, exp, xfer_count - start);
	endtask

	// four back-to-back hits stream one response per cycle behind two register stages
	task automatic stream_hits(input string name, input logic [ADDR_W-1:0] base);
		int exp;
		int start;
		int edges;
		int got;
		exp = 0;
		edges = 0;
		got = 0;
		for (int i = 0; i < 4; i++)
			exp += model_access(base + 32'(4 * i));
		start = xfer_count;
		fork
			begin
				for (int i = 0; i < 4; i++)
					send_req(base + 32'(4 * i));
			end
			begin
				while (got < 4) begin
					@(negedge clk);
					if (resp_valid && resp_ready)
						got++;
					@(posedge clk);
					edges++;
				end
			end
		join
		#1;
		check_value({name, " cycles"}, 4 + 2, edges);
		check_value({name, " apb count"}, exp, xfer_count - start);
	endtask

	initial begin
		logic [ADDR_W-1:0] base;
		logic [ADDR_W-1:0] addr;
		int exp;
		int start;
		void'($urandom(34));
		rst = 1'b1;
		req_valid = 1'b0;
		req_addr = '0;
		resp_ready = 1'b1;
		flush = 1'b0;
		m_ptr = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		@(negedge clk);
		if (!req_ready || resp_valid || psel || penable)
			abort_run("fetch or apb outputs not idle after reset");
		@(posedge clk);
		#1;

		// cold miss fetches the four words of the line in order
		base = 32'h0000_1240;
		apb_log.delete();
		fetch("cold_miss", base + 32'h8, 0);
		check_value("cold_miss apb count", 4, apb_log.size());
		for (int i = 0; i < 4; i++)
			check_value("cold_miss paddr", base + 32'(4 * i), apb_log[i]);

		for (int r = 0; r < 2; r++) begin
			for (int i = 0; i < 4; i++)
				fetch("hit_offsets", base + 32'(4 * i), 0);
		end
		stream_hits("hit_stream", base);

		for (int i = 0; i < 6; i++) begin
			addr = $urandom & 32'h0000_07FC;
			fetch("backpressure", addr, $urandom_range(6, 1));
		end

		// flush while a hit response waits
		void'(model_access(base));
		resp_ready = 1'b0;
		send_req(base);
		@(negedge clk);
		while (!resp_valid)
			@(negedge clk);
		@(posedge clk);
		#1;
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		resp_ready = 1'b1;

		// flush in the middle of a refill and the line still lands in the array
		addr = 32'h0000_5A30;
		exp = model_access(addr);
		start = xfer_count;
		send_req(addr);
		@(negedge clk);
		while (!psel)
			@(negedge clk);
		@(posedge clk);
		#1;
		flush = 1'b1;
		@(posedge clk);
		#1;
		flush = 1'b0;
		@(negedge clk);
		while (psel)
			@(negedge clk);
		@(posedge clk);
		#1;
		check_value("flush_refill apb count", exp, xfer_count - start);
		fetch("flush_refill refetch", addr, 0);

		// five tags on one set and then a refetch against the mirror
		for (int r = 0; r < 2; r++) begin
			for (int t = 0; t < 5; t++)
				fetch("replacement", {TAG_W'(t + 'h300), INDEX_W'(42), 4'h4}, 0);
		end

		repeat (4) @(posedge clk);
		if (UUT.u_props.fail_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run("a bound assertion reported a failure");
		end
	end

endmodule

`default_nettype wire

//--- source/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way import icache_pkg::*; #(
	parameter int SETS = 64
) (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic [INDEX_W-1:0] lk_index,
	input  wire logic [TAG_W-1:0]   lk_tag,
	input  wire logic               lk_read,
	input  wire logic               fill_en,
	input  wire logic [LINE_W-1:0]  refill_line,
	output logic                    hit,
	output logic [LINE_W-1:0]       line_out
);

	logic [SETS-1:0]   valid;
	logic [TAG_W-1:0]  tags [SETS];
	logic [LINE_W-1:0] lines [SETS];

	assign hit = valid[lk_index] && (tags[lk_index] == lk_tag);

	always_ff @(posedge clk) begin
		if (rst)
			valid <= '0;
		else if (fill_en)
			valid[lk_index] <= 1'b1;
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tags[lk_index] <= lk_tag;
			lines[lk_index] <= refill_line;
		end
	end

	// read port, only the hitting way loads its output
	always_ff @(posedge clk) begin
		if (lk_read && hit)
			line_out <= lines[lk_index];
	end

endmodule

`default_nettype wire

//--- source/fetch_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_lookup import icache_pkg::*; #(
	parameter int NUM_WAYS = 4
) (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                req_valid,
	input  wire logic [ADDR_W-1:0]   req_addr,
	input  wire logic                flush,
	input  wire logic [NUM_WAYS-1:0] hit,
	input  wire logic                refill_done,
	input  wire logic                resp_pending,
	output logic                     req_ready,
	output logic [INDEX_W-1:0]       lk_index,
	output logic [TAG_W-1:0]         lk_tag,
	output logic                     lk_read,
	output logic [NUM_WAYS-1:0]      fill_en,
	output logic                     refill_start,
	output logic [ADDR_W-1:0]        refill_base,
	output logic [NUM_WAYS-1:0]      sel_way,
	output logic [1:0]               word_off,
	output logic                     load
);

	typedef enum logic {S_IDLE, S_WAIT} state_t;

	state_t                     state;
	logic                       flushed;
	logic                       accept;
	logic                       miss;
	logic [ADDR_W-OFFSET_W-1:0] line_q;
	logic [NUM_WAYS-1:0]        rot_ptr;
	logic [NUM_WAYS-1:0]        victim_q;

	// a refill response still sitting in the load stage blocks new requests
	assign req_ready = (state == S_IDLE) && !flush && !resp_pending &&
		!(load && sel_way == '0);
	assign accept = req_valid && req_ready;
	assign miss = accept && (hit == '0);

	// ways see the live address when idle, the held one while refilling
	assign lk_index = (state == S_IDLE) ? req_addr[OFFSET_W +: INDEX_W] : line_q[INDEX_W-1:0];
	assign lk_tag = (state == S_IDLE) ? req_addr[ADDR_W-1 -: TAG_W] : line_q[INDEX_W +: TAG_W];
	assign lk_read = accept;

	assign refill_base = {line_q, {OFFSET_W{1'b0}}};
	assign fill_en = (state == S_WAIT && refill_done) ? victim_q : '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			flushed <= 1'b0;
			refill_start <= 1'b0;
			rot_ptr <= NUM_WAYS'(1);
			sel_way <= '0;
		end else begin
			refill_start <= miss;
			if (accept) begin
				rot_ptr <= {rot_ptr[NUM_WAYS-2:0], rot_ptr[NUM_WAYS-1]};
				// zero on a miss, which later selects the refill line
				sel_way <= hit;
			end
			if (miss) begin
				state <= S_WAIT;
				flushed <= 1'b0;
			end else if (state == S_WAIT) begin
				if (refill_done)
					state <= S_IDLE;
				if (flush)
					flushed <= 1'b1;
			end
		end
	end

	// request payload and victim, captured at acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			line_q <= req_addr[ADDR_W-1:OFFSET_W];
			word_off <= req_addr[3:2];
			victim_q <= rot_ptr;
		end
	end

	// load stays up until inst_select can take it
	always_ff @(posedge clk) begin
		if (rst)
			load <= 1'b0;
		else if (flush)
			load <= 1'b0;
		else if (accept && hit != '0)
			load <= 1'b1;
		else if (state == S_WAIT && refill_done && !flushed)
			load <= 1'b1;
		else if (!resp_pending)
			load <= 1'b0;
	end

endmodule

`default_nettype wire

//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// fetch address and instruction word
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	// line geometry, four words per line
	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;

	// address split: tag | index | byte offset
	localparam int OFFSET_W = 4;
	localparam int INDEX_W = 6;
	localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

endpackage

`default_nettype wire

//--- source/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; #(
	parameter int NUM_WAYS = 4,
	parameter int SETS = 64
) (
	input  wire logic              clk,
	input  wire logic              rst,

	// fetch side
	input  wire logic              req_valid,
	input  wire logic [ADDR_W-1:0] req_addr,
	output logic                   req_ready,
	output logic                   resp_valid,
	output logic [WORD_W-1:0]      resp_inst,
	input  wire logic              resp_ready,
	input  wire logic              flush,

	// apb read requester
	output logic                   psel,
	output logic                   penable,
	output logic [ADDR_W-1:0]      paddr,
	input  wire logic [31:0]       prdata,
	input  wire logic              pready
);

	logic [INDEX_W-1:0]         lk_index;
	logic [TAG_W-1:0]           lk_tag;
	logic                       lk_read;
	logic [NUM_WAYS-1:0]        hit;
	logic [NUM_WAYS-1:0]        fill_en;
	logic                       refill_start;
	logic [ADDR_W-1:0]          refill_base;
	logic                       refill_done;
	logic [LINE_W-1:0]          refill_line;
	logic [NUM_WAYS-1:0]        sel_way;
	logic [1:0]                 word_off;
	logic                       load;
	logic                       resp_pending;
	logic [NUM_WAYS*LINE_W-1:0] way_lines;

	fetch_lookup #(
		.NUM_WAYS(NUM_WAYS)
	) u_lookup (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.flush(flush),
		.hit(hit),
		.refill_done(refill_done),
		.resp_pending(resp_pending),
		.req_ready(req_ready),
		.lk_index(lk_index),
		.lk_tag(lk_tag),
		.lk_read(lk_read),
		.fill_en(fill_en),
		.refill_start(refill_start),
		.refill_base(refill_base),
		.sel_way(sel_way),
		.word_off(word_off),
		.load(load)
	);

	refill_apb_master u_refill (
		.clk(clk),
		.rst(rst),
		.refill_start(refill_start),
		.refill_base(refill_base),
		.prdata(prdata),
		.pready(pready),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.refill_done(refill_done),
		.refill_line(refill_line)
	);

	// one way per generate step, all sharing the lookup broadcast
	for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
		cache_way #(
			.SETS(SETS)
		) u_way (
			.clk(clk),
			.rst(rst),
			.lk_index(lk_index),
			.lk_tag(lk_tag),
			.lk_read(lk_read),
			.fill_en(fill_en[g]),
			.refill_line(refill_line),
			.hit(hit[g]),
			.line_out(way_lines[g*LINE_W +: LINE_W])
		);
	end

	inst_select #(
		.NUM_WAYS(NUM_WAYS)
	) u_select (
		.clk(clk),
		.rst(rst),
		.load(load),
		.sel_way(sel_way),
		.word_off(word_off),
		.line_in(way_lines),
		.refill_line(refill_line),
		.resp_ready(resp_ready),
		.flush(flush),
		.resp_valid(resp_valid),
		.resp_inst(resp_inst),
		.resp_pending(resp_pending)
	);

endmodule

`default_nettype wire

//--- source/inst_select.sv
`timescale 1ns/1ps
`default_nettype none

module inst_select import icache_pkg::*; #(
	parameter int NUM_WAYS = 4
) (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       load,
	input  wire logic [NUM_WAYS-1:0]        sel_way,
	input  wire logic [1:0]                 word_off,
	input  wire logic [NUM_WAYS*LINE_W-1:0] line_in,
	input  wire logic [LINE_W-1:0]          refill_line,
	input  wire logic                       resp_ready,
	input  wire logic                       flush,
	output logic                            resp_valid,
	output logic [WORD_W-1:0]               resp_inst,
	output logic                            resp_pending
);

	logic [LINE_W-1:0] line_pick;
	logic              capture;

	// response held and not taken this cycle
	assign resp_pending = resp_valid && !resp_ready;
	assign capture = load && !resp_pending && !flush;

	// one-hot way select, all-zero means the refill line
	always_comb begin
		line_pick = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (sel_way[w])
				line_pick = line_pick | line_in[w*LINE_W +: LINE_W];
		end
		if (sel_way == '0)
			line_pick = refill_line;
	end

	always_ff @(posedge clk) begin
		if (rst)
			resp_valid <= 1'b0;
		else if (flush)
			resp_valid <= 1'b0;
		else if (capture)
			resp_valid <= 1'b1;
		else if (resp_ready)
			resp_valid <= 1'b0;
	end

	// word stays put under stall since capture is blocked
	always_ff @(posedge clk) begin
		if (capture)
			resp_inst <= line_pick[word_off*WORD_W +: WORD_W];
	end

endmodule

`default_nettype wire

//--- source/refill_apb_master.sv
`timescale 1ns/1ps
`default_nettype none

module refill_apb_master import icache_pkg::*; (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              refill_start,
	input  wire logic [ADDR_W-1:0] refill_base,
	input  wire logic [WORD_W-1:0] prdata,
	input  wire logic              pready,
	output logic                   psel,
	output logic                   penable,
	output logic [ADDR_W-1:0]      paddr,
	output logic                   refill_done,
	output logic [LINE_W-1:0]      refill_line
);

	localparam int CNT_W = $clog2(WORDS_PER_LINE);

	typedef enum logic [1:0] {R_IDLE, R_SETUP, R_ACCESS} state_t;

	state_t                     state;
	logic [CNT_W-1:0]           cnt;
	logic [ADDR_W-OFFSET_W-1:0] line_q;
	logic                       last;

	assign psel = (state != R_IDLE);
	assign penable = (state == R_ACCESS);
	// word address within the line, byte lanes always zero
	assign paddr = {line_q, cnt, 2'b00};
	assign last = (cnt == CNT_W'(WORDS_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= R_IDLE;
			cnt <= '0;
			refill_done <= 1'b0;
		end else begin
			refill_done <= 1'b0;
			case (state)
				R_IDLE: begin
					if (refill_start) begin
						cnt <= '0;
						state <= R_SETUP;
					end
				end
				R_SETUP: begin
					state <= R_ACCESS;
				end
				R_ACCESS: begin
					// wait states keep us here
					if (pready) begin
						cnt <= cnt + 1'b1;
						if (last) begin
							state <= R_IDLE;
							refill_done <= 1'b1;
						end else begin
							state <= R_SETUP;
						end
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == R_IDLE && refill_start)
			line_q <= refill_base[ADDR_W-1:OFFSET_W];
		// each returned word lands at its slot in the line
		if (state == R_ACCESS && pready)
			refill_line[cnt*WORD_W +: WORD_W] <= prdata;
	end

endmodule

`default_nettype wire

//--- tb.f
source/icache_pkg.sv
source/cache_way.sv
source/fetch_lookup.sv
source/refill_apb_master.sv
source/inst_select.sv
source/icache_top.sv
dv/icache_properties.sv
dv/tb_icache.sv
